//--- tb/sa_patterns.txt
# ifm0 ifm1 w00 w01 w10 w11 repeat
# operands in hex, bit 7 sign and bits 6:0 magnitude; repeat in decimal adds random-input runs
00 00 00 00 00 00 0
7f 7f 7f 7f 7f 7f 0
ff ff 7f 7f 7f 7f 0
7f ff ff 7f 7f ff 0
40 20 40 20 10 7f 0
01 01 01 01 01 01 0
7f 7f 01 40 00 80 0
55 aa 00 80 7f ff 0
c0 a0 c0 20 90 7f 0
3c 4b 15 2a 6e 33 4
c1 27 9a 0f 61 d4 4
10 70 ff 80 05 7a 3

//--- vlog.f
source/usys_pkg.sv
source/mul_border.sv
source/acc.sv
source/pe_border.sv
source/pe_inner.sv
source/sa_ctrl.sv
source/sa_top.sv
tb/tb_sa_top.sv

//--- tb/tb_sa_top.sv
`default_nettype none

module tb_sa_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_LINES    = 64;
    localparam int NFIELDS      = usys_pkg::ROWS + usys_pkg::ROWS * usys_pkg::COLS;

    logic                        clk = 1'b0;
    logic                        rst_n_i;
    logic                        start_i;
    usys_pkg::operand_t          ifm_i  [usys_pkg::ROWS];
    usys_pkg::operand_t          wght_i [usys_pkg::ROWS][usys_pkg::COLS];
    logic                        busy_o;
    logic                        done_o;
    logic [usys_pkg::OWIDTH-1:0] ofm_o  [usys_pkg::COLS];

    usys_pkg::operand_t cur_ifm  [usys_pkg::ROWS];     // operands of the run in flight
    usys_pkg::operand_t cur_wght [usys_pkg::ROWS][usys_pkg::COLS];
    logic [7:0]         pat_val  [MAX_LINES][NFIELDS];
    int                 pat_rep  [MAX_LINES];
    int                 n_lines  = 0;
    int                 n_tests  = 0;
    int                 done_cnt = 0;
    int                 starts   = 0;
    int                 pass_cnt = 0;
    int                 fail_cnt = 0;
    int                 test_errs;
    int                 seed     = 43078;

    sa_top u_dut (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .start_i (start_i),
        .ifm_i   (ifm_i),
        .wght_i  (wght_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .ofm_o   (ofm_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (rst_n_i === 1'b1 && done_o === 1'b1) begin
            done_cnt++;
        end
    end

    task automatic load_patterns();
        int            fd;
        int            got;
        int            total;
        logic [1023:0] line;
        total = 0;
        fd = $fopen("tb/sa_patterns.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0 && n_lines < MAX_LINES) begin
                got = $sscanf(line, "%h %h %h %h %h %h %d", pat_val[n_lines][0],
                              pat_val[n_lines][1], pat_val[n_lines][2], pat_val[n_lines][3],
                              pat_val[n_lines][4], pat_val[n_lines][5], pat_rep[n_lines]);
                if (got == 7) begin     // comment lines scan nothing
                    total += pat_rep[n_lines] + 1;
                    n_lines++;
                end
            end
            $fclose(fd);
        end
        n_tests = (n_lines > 0) ? total + 1 : 0;     // plus the reset check
    endtask

    // signed count of one element, straight from the unary multiply rule
    function automatic int signed_count(input usys_pkg::operand_t x, input usys_pkg::operand_t w);
        int                          cnt;
        int                          t;
        int                          b;
        logic [usys_pkg::MWIDTH-1:0] t_bits;
        logic [usys_pkg::MWIDTH-1:0] rev;
        cnt = 0;
        for (t = 0; t < usys_pkg::SLEN; t++) begin
            t_bits = t[usys_pkg::MWIDTH-1:0];
            for (b = 0; b < usys_pkg::MWIDTH; b++) begin
                rev[b] = t_bits[usys_pkg::MWIDTH-1-b];
            end
            if (t < x.mag && rev < w.mag) begin
                cnt++;
            end
        end
        return (x.sign != w.sign) ? -cnt : cnt;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic drive_junk();
        int rnd;
        for (int r = 0; r < usys_pkg::ROWS; r++) begin
            rnd = $random(seed);
            ifm_i[r] = rnd[usys_pkg::IWIDTH-1:0];
            for (int c = 0; c < usys_pkg::COLS; c++) begin
                rnd = $random(seed);
                wght_i[r][c] = rnd[usys_pkg::IWIDTH-1:0];
            end
        end
    endtask

    task automatic report_test(input int test_no);
        if (test_errs == 0) begin
            $display("test %0d ok", test_no);
            pass_cnt++;
        end else begin
            $display("test %0d failed with %0d errors", test_no, test_errs);
            fail_cnt++;
        end
    endtask

    // one accepted run; poke adds starts while busy that must be dropped
    task automatic run_pattern(input int test_no, input bit poke);
        logic [usys_pkg::OWIDTH-1:0] exp_sum [usys_pkg::COLS];
        logic [usys_pkg::OWIDTH-1:0] held    [usys_pkg::COLS];
        int                          total;
        int                          cyc;
        bit                          seen;
        test_errs = 0;
        for (int c = 0; c < usys_pkg::COLS; c++) begin
            total = 0;
            for (int r = 0; r < usys_pkg::ROWS; r++) begin
                total += signed_count(cur_ifm[r], cur_wght[r][c]);
            end
            exp_sum[c] = total[usys_pkg::OWIDTH-1:0];
        end
        ifm_i   = cur_ifm;
        wght_i  = cur_wght;
        start_i = 1'b1;
        starts++;
        @(posedge clk);
        #DRIVE_DLY;
        start_i = 1'b0;
        drive_junk();     // operands only count on the accept edge
        seen = 1'b0;
        for (cyc = 0; cyc < usys_pkg::SLEN + 20 && !seen; cyc++) begin
            if (done_o === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_eq("busy_o", busy_o, 1);
                // mid stream, and in the tail where the sequencer is idle but busy
                start_i = poke && (cyc == 20 || cyc == usys_pkg::SLEN + 2);
                @(posedge clk);
                #DRIVE_DLY;
            end
        end
        assert (seen) else begin
            $display("test %0d: done_o never came after the start", test_no);
            test_errs++;
        end
        check_eq("busy_o", busy_o, 0);
        for (int c = 0; c < usys_pkg::COLS; c++) begin
            check_eq($sformatf("ofm_o[%0d]", c), ofm_o[c], exp_sum[c]);
            held[c] = ofm_o[c];
        end
        @(posedge clk);
        #DRIVE_DLY;
        check_eq("done_o", done_o, 0);     // single cycle pulse
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        for (int c = 0; c < usys_pkg::COLS; c++) begin
            check_eq($sformatf("ofm_o[%0d]", c), ofm_o[c], held[c]);
        end
        assert (done_cnt == starts) else begin
            $display("%0d starts accepted but %0d done_o pulses seen", starts, done_cnt);
            test_errs++;
        end
        report_test(test_no);
    endtask

    initial begin
        int rnd;
        int test_no;
        rst_n_i = 1'b0;
        start_i = 1'b0;
        for (int r = 0; r < usys_pkg::ROWS; r++) begin
            ifm_i[r] = '0;
            for (int c = 0; c < usys_pkg::COLS; c++) begin
                wght_i[r][c] = '0;
            end
        end
        load_patterns();
        if (n_lines == 0) begin
            $display("no pattern could be read from tb/sa_patterns.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DLY;
            rst_n_i = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            test_errs = 0;
            check_eq("busy_o", busy_o, 0);
            check_eq("done_o", done_o, 0);
            for (int c = 0; c < usys_pkg::COLS; c++) begin
                check_eq($sformatf("ofm_o[%0d]", c), ofm_o[c], 0);
            end
            report_test(0);
            test_no = 1;
            for (int l = 0; l < n_lines; l++) begin
                for (int k = 0; k <= pat_rep[l]; k++) begin
                    for (int r = 0; r < usys_pkg::ROWS; r++) begin
                        rnd = $random(seed);
                        cur_ifm[r] = (k == 0) ? pat_val[l][r] : rnd[usys_pkg::IWIDTH-1:0];
                        for (int c = 0; c < usys_pkg::COLS; c++) begin
                            cur_wght[r][c] = pat_val[l][usys_pkg::ROWS + r * usys_pkg::COLS + c];
                        end
                    end
                    run_pattern(test_no, test_no % 2 == 0);
                    test_no++;
                end
            end
            $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

    // budget per run covers the fixed latency with margin
    initial begin
        wait (n_tests > 0);
        #((n_tests * (usys_pkg::SLEN + 20) + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not finish within the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/sa_top.sv
`default_nettype none

module sa_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    input  usys_pkg::operand_t          ifm_i  [usys_pkg::ROWS],
    input  usys_pkg::operand_t          wght_i [usys_pkg::ROWS][usys_pkg::COLS],
    output logic                        busy_o,
    output logic                        done_o,
    output logic [usys_pkg::OWIDTH-1:0] ofm_o  [usys_pkg::COLS]
);

    usys_pkg::operand_t          ifm_q  [usys_pkg::ROWS];
    usys_pkg::operand_t          wght_q [usys_pkg::ROWS][usys_pkg::COLS];
    usys_pkg::pe_ctrl_t          row_ctrl [usys_pkg::ROWS];
    usys_pkg::pe_ctrl_t          ctrl_fwd [usys_pkg::ROWS][usys_pkg::COLS];
    logic                        ibit_fwd [usys_pkg::ROWS][usys_pkg::COLS];
    logic                        sign_fwd [usys_pkg::ROWS][usys_pkg::COLS];
    usys_pkg::seq_t              seq_fwd  [usys_pkg::ROWS][usys_pkg::COLS];
    logic [usys_pkg::OWIDTH-1:0] psum     [usys_pkg::ROWS+1][usys_pkg::COLS];   // row 0 is zero
    logic                        accept;
    logic                        last_done;

    assign accept    = start_i && !busy_o;
    assign last_done = ctrl_fwd[usys_pkg::ROWS-1][usys_pkg::COLS-1].mac_done;

    // operands captured on accept, skewed rows load from here later
    always_ff @(posedge clk) begin
        if (accept) begin
            ifm_q  <= ifm_i;
            wght_q <= wght_i;
        end
    end

    sa_ctrl u_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .done_i     (last_done),
        .busy_o     (busy_o),
        .row_ctrl_o (row_ctrl)
    );

    for (genvar r = 0; r < usys_pkg::ROWS; r++) begin : g_row
        pe_border u_border (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .ctrl_i  (row_ctrl[r]),
            .ifm_i   (ifm_q[r]),
            .wght_i  (wght_q[r][0]),
            .sum_i   (psum[r][0]),
            .ctrl_o  (ctrl_fwd[r][0]),
            .ibit_o  (ibit_fwd[r][0]),
            .isign_o (sign_fwd[r][0]),
            .seq_o   (seq_fwd[r][0]),
            .sum_o   (psum[r+1][0])
        );

        for (genvar c = 1; c < usys_pkg::COLS; c++) begin : g_col
            pe_inner u_inner (
                .clk     (clk),
                .rst_n_i (rst_n_i),
                .ctrl_i  (ctrl_fwd[r][c-1]),
                .ibit_i  (ibit_fwd[r][c-1]),
                .isign_i (sign_fwd[r][c-1]),
                .seq_i   (seq_fwd[r][c-1]),
                .wght_i  (wght_q[r][c]),
                .sum_i   (psum[r][c]),
                .ctrl_o  (ctrl_fwd[r][c]),
                .ibit_o  (ibit_fwd[r][c]),
                .isign_o (sign_fwd[r][c]),
                .seq_o   (seq_fwd[r][c]),
                .sum_o   (psum[r+1][c])
            );
        end
    end

    for (genvar c = 0; c < usys_pkg::COLS; c++) begin : g_out
        assign psum[0][c] = '0;
        assign ofm_o[c]   = psum[usys_pkg::ROWS][c];
    end

    // bottom right element finishes last
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= last_done;
        end
    end

endmodule

`default_nettype wire

//--- source/sa_ctrl.sv
`default_nettype none

module sa_ctrl (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  logic               done_i,
    output logic               busy_o,
    output usys_pkg::pe_ctrl_t row_ctrl_o [usys_pkg::ROWS]
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_STREAM
    } state_t;

    state_t                     state_q;
    logic [usys_pkg::STEPW-1:0] step_q;
    logic                       accept;
    logic                       last_step;
    usys_pkg::pe_ctrl_t         row0;

    assign accept    = start_i && !busy_o;     // extra starts dropped while busy
    assign last_step = (step_q == usys_pkg::SLEN);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state_q <= S_STREAM;
                    step_q  <= '0;
                end
                S_STREAM: begin
                    step_q <= step_q + 1'b1;
                    if (last_step) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // busy spans the whole array pipeline, not just the stream
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_o <= 1'b0;
        end else if (accept) begin
            busy_o <= 1'b1;
        end else if (done_i) begin
            busy_o <= 1'b0;
        end
    end

    always_comb begin
        row0 = '0;
        case (state_q)
            S_LOAD: begin
                row0.en_i  = 1'b1;
                row0.en_w  = 1'b1;
                row0.clr_o = 1'b1;     // counts restart with the load
            end
            S_STREAM: begin
                row0.en_o     = !last_step;
                row0.mac_done = last_step;
                row0.clr_i    = last_step;     // operands no longer needed
                row0.clr_w    = last_step;
            end
            default: ;
        endcase
    end

    assign row_ctrl_o[0] = row0;

    // one cycle of skew per row
    if (usys_pkg::ROWS > 1) begin : g_skew
        usys_pkg::pe_ctrl_t skew_q [usys_pkg::ROWS-1];

        always_ff @(posedge clk) begin
            if (!rst_n_i) begin
                for (int i = 0; i < usys_pkg::ROWS - 1; i++) begin
                    skew_q[i] <= '0;
                end
            end else begin
                skew_q[0] <= row0;
                for (int i = 1; i < usys_pkg::ROWS - 1; i++) begin
                    skew_q[i] <= skew_q[i-1];
                end
            end
        end

        for (genvar r = 1; r < usys_pkg::ROWS; r++) begin : g_row
            assign row_ctrl_o[r] = skew_q[r-1];
        end
    end

endmodule

`default_nettype wire

//--- source/pe_inner.sv
`default_nettype none

module pe_inner (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  usys_pkg::pe_ctrl_t          ctrl_i,
    input  logic                        ibit_i,
    input  logic                        isign_i,
    input  usys_pkg::seq_t              seq_i,
    input  usys_pkg::operand_t          wght_i,
    input  logic [usys_pkg::OWIDTH-1:0] sum_i,
    output usys_pkg::pe_ctrl_t          ctrl_o,
    output logic                        ibit_o,
    output logic                        isign_o,
    output usys_pkg::seq_t              seq_o,
    output logic [usys_pkg::OWIDTH-1:0] sum_o
);

    usys_pkg::operand_t wght_q;
    logic               wbit;
    logic               prod;
    logic               neg;

    always_ff @(posedge clk) begin
        if (ctrl_i.clr_w) begin
            wght_q <= '0;
        end else if (ctrl_i.en_w) begin
            wght_q <= wght_i;
        end
    end

    // same sequence as the border, one cycle later per column
    assign wbit = (seq_i < wght_q.mag);
    assign prod = ibit_i & wbit;
    assign neg  = isign_i ^ wght_q.sign;

    acc u_acc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .en_i       (ctrl_i.en_o),
        .clr_i      (ctrl_i.clr_o),
        .mac_done_i (ctrl_o.mac_done),
        .prod_i     (prod),
        .neg_i      (neg),
        .sum_i      (sum_i),
        .sum_o      (sum_o)
    );

    // stream forwarding to the right
    always_ff @(posedge clk) begin
        ibit_o  <= ibit_i;
        isign_o <= isign_i;
        seq_o   <= seq_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o <= ctrl_i;
        end
    end

endmodule

`default_nettype wire

//--- source/pe_border.sv
`default_nettype none

module pe_border (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  usys_pkg::pe_ctrl_t          ctrl_i,
    input  usys_pkg::operand_t          ifm_i,
    input  usys_pkg::operand_t          wght_i,
    input  logic [usys_pkg::OWIDTH-1:0] sum_i,
    output usys_pkg::pe_ctrl_t          ctrl_o,
    output logic                        ibit_o,
    output logic                        isign_o,
    output usys_pkg::seq_t              seq_o,
    output logic [usys_pkg::OWIDTH-1:0] sum_o
);

    usys_pkg::operand_t ifm_q;
    usys_pkg::operand_t wght_q;
    logic               prod;
    logic               neg;

    // operand registers
    always_ff @(posedge clk) begin
        if (ctrl_i.clr_i) begin
            ifm_q <= '0;
        end else if (ctrl_i.en_i) begin
            ifm_q <= ifm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.clr_w) begin
            wght_q <= '0;
        end else if (ctrl_i.en_w) begin
            wght_q <= wght_i;
        end
    end

    mul_border u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (ctrl_i.en_o),
        .clr_i   (ctrl_i.clr_o),
        .mag_i   (ifm_q.mag),
        .wmag_i  (wght_q.mag),
        .seq_o   (seq_o),
        .ibit_o  (ibit_o),
        .prod_o  (prod)
    );

    assign neg = ifm_q.sign ^ wght_q.sign;

    // sum latched on the delayed done, so the row above is already settled
    acc u_acc (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .en_i       (ctrl_i.en_o),
        .clr_i      (ctrl_i.clr_o),
        .mac_done_i (ctrl_o.mac_done),
        .prod_i     (prod),
        .neg_i      (neg),
        .sum_i      (sum_i),
        .sum_o      (sum_o)
    );

    always_ff @(posedge clk) begin
        isign_o <= ifm_q.sign;     // lines up with ibit_o
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o <= ctrl_i;
        end
    end

endmodule

`default_nettype wire

//--- source/acc.sv
`default_nettype none

module acc (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        clr_i,
    input  logic                        mac_done_i,
    input  logic                        prod_i,
    input  logic                        neg_i,
    input  logic [usys_pkg::OWIDTH-1:0] sum_i,
    output logic [usys_pkg::OWIDTH-1:0] sum_o
);

    logic [usys_pkg::CNTW-1:0]   cnt_q;     // two's complement
    logic [usys_pkg::OWIDTH-1:0] cnt_ext;

    assign cnt_ext = {{(usys_pkg::OWIDTH - usys_pkg::CNTW){cnt_q[usys_pkg::CNTW-1]}}, cnt_q};

    // product sign applied per counted one
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (en_i && prod_i) begin
            if (neg_i) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // partial sum from above plus own share, held until next clear
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sum_o <= '0;
        end else if (clr_i) begin
            sum_o <= '0;
        end else if (mac_done_i) begin
            sum_o <= sum_i + cnt_ext;
        end
    end

endmodule

`default_nettype wire

//--- source/mul_border.sv
`default_nettype none

module mul_border (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        clr_i,
    input  logic [usys_pkg::MWIDTH-1:0] mag_i,
    input  logic [usys_pkg::MWIDTH-1:0] wmag_i,
    output usys_pkg::seq_t              seq_o,
    output logic                        ibit_o,
    output logic                        prod_o
);

    logic [usys_pkg::MWIDTH-1:0] step_q;
    usys_pkg::seq_t              seq;
    logic                        ibit;
    logic                        wbit;

    // stream position, restarts with each load
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            step_q <= '0;
        end else if (clr_i) begin
            step_q <= '0;
        end else if (en_i) begin
            step_q <= step_q + 1'b1;
        end
    end

    // rate code: ones for the first mag_i steps
    assign ibit = (step_q < mag_i);

    // reversed step spreads weight ones evenly over the stream
    always_comb begin
        for (int b = 0; b < usys_pkg::MWIDTH; b++) begin
            seq[b] = step_q[usys_pkg::MWIDTH-1-b];
        end
    end

    assign wbit   = (seq < wmag_i);
    assign prod_o = ibit & wbit;     // unary multiply

    // handed to the next column one cycle later
    always_ff @(posedge clk) begin
        ibit_o <= ibit;
        seq_o  <= seq;
    end

endmodule

`default_nettype wire

//--- source/usys_pkg.sv
`default_nettype none

package usys_pkg;

    // array shape
    localparam int ROWS = 2;
    localparam int COLS = 2;

    localparam int IWIDTH = 8;               // sign + magnitude
    localparam int MWIDTH = IWIDTH - 1;
    localparam int SLEN   = 1 << MWIDTH;     // stream cycles per run
    localparam int OWIDTH = 16;              // two's complement column sum

    localparam int STEPW = MWIDTH + 1;       // controller step, reaches SLEN
    localparam int CNTW  = MWIDTH + 2;       // signed product count per element

    // control bundle, rippled right and down the array
    typedef struct packed {
        logic en_i;
        logic clr_i;
        logic en_w;
        logic clr_w;
        logic en_o;
        logic clr_o;
        logic mac_done;
    } pe_ctrl_t;

    typedef struct packed {
        logic              sign;
        logic [MWIDTH-1:0] mag;
    } operand_t;

    // weight comparison word
    typedef logic [MWIDTH-1:0] seq_t;

endpackage

`default_nettype wire
